// ==== hw/video_pkg.sv ====
package video_pkg;

    // Screen position of up to 1024 on either axis
    typedef logic [9:0]  coord_t;

    // RGB565 colour with red on top and blue in the low bits
    typedef logic [15:0] rgb565_t;

    localparam int w_red   = 5;
    localparam int w_green = 6;
    localparam int w_blue  = 5;

    localparam rgb565_t rgb_black = 16'h0000;
    localparam rgb565_t rgb_white = 16'hffff;

    //------------------------------------------------------------------------

    typedef struct packed
    {
        coord_t  x;
        coord_t  y;
        rgb565_t color;
        logic    eof;     // Last pixel of the frame
    } pixel_t;

    //------------------------------------------------------------------------

    function automatic rgb565_t pack_rgb565
    (
        logic [w_red   - 1:0] red,
        logic [w_green - 1:0] green,
        logic [w_blue  - 1:0] blue
    );
        return {red, green, blue};
    endfunction

endpackage

// ==== hw/engine_pkg.sv ====
package engine_pkg;

    typedef enum logic [1:0]
    {
        pat_gradient = 2'd0,
        pat_checker  = 2'd1,
        pat_solid    = 2'd2,
        pat_bars     = 2'd3
    } pattern_mode_t;

    typedef enum logic
    {
        st_idle = 1'b0,
        st_run  = 1'b1
    } disp_state_t;

    // One coordinate sent from the dispatcher to a lane
    typedef struct packed
    {
        video_pkg::coord_t  x;
        video_pkg::coord_t  y;
        pattern_mode_t      mode;
        video_pkg::rgb565_t fill;
        logic               eof;
    } lane_req_t;

endpackage

// ==== hw/pixel_dispatcher.sv ====
module pixel_dispatcher
# (
    parameter int screen_width  = 640,
    parameter int screen_height = 480,
    parameter int n_lanes       = 4,
    parameter int lane_depth    = 2
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  engine_pkg::pattern_mode_t mode,
    input  video_pkg::rgb565_t        fill,
    input  logic [n_lanes - 1:0]      credit_ret,
    output logic [n_lanes - 1:0]      req_valid,
    output engine_pkg::lane_req_t     req,
    output logic                      busy_start
);

    import video_pkg::*;
    import engine_pkg::*;

    localparam int w_lane   = n_lanes > 1 ? $clog2 (n_lanes) : 1;
    localparam int w_credit = $clog2 (lane_depth + 1);

    disp_state_t           state;
    pattern_mode_t         mode_q;
    rgb565_t               fill_q;
    coord_t                x;
    coord_t                y;
    logic [w_lane   - 1:0] lane_ptr;
    logic [w_credit - 1:0] credit_cnt [n_lanes];
    logic                  credits_full;
    logic                  last_x;
    logic                  last_y;
    logic                  send;

    //------------------------------------------------------------------------

    // All credits home means the previous frame has fully left the lanes
    always_comb
    begin
        credits_full = 1'b1;
        for (int k = 0; k < n_lanes; k++)
        begin
            if (credit_cnt[k] != w_credit'(lane_depth))
                credits_full = 1'b0;
        end
    end

    assign busy_start = (state == st_idle) && start && credits_full;

    assign last_x = (x == coord_t'(screen_width  - 1));
    assign last_y = (y == coord_t'(screen_height - 1));
    assign send   = (state == st_run) && (credit_cnt[lane_ptr] != '0);

    always_comb
    begin
        req_valid = '0;
        if (send)
            req_valid[lane_ptr] = 1'b1;
    end

    assign req = '{x: x, y: y, mode: mode_q, fill: fill_q, eof: last_x && last_y};

    //------------------------------------------------------------------------

    // Raster walk
    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            state    <= st_idle;
            x        <= '0;
            y        <= '0;
            lane_ptr <= '0;
        end
        else if (busy_start)
        begin
            state    <= st_run;
            x        <= '0;
            y        <= '0;
            lane_ptr <= '0;
        end
        else if (send)
        begin
            lane_ptr <= (lane_ptr == w_lane'(n_lanes - 1)) ? '0 : lane_ptr + 1'b1;

            if (last_x)
            begin
                x <= '0;
                if (last_y)
                    state <= st_idle;
                else
                    y <= y + 1'b1;
            end
            else
            begin
                x <= x + 1'b1;
            end
        end
    end

    // Frame settings held for the whole frame
    always_ff @ (posedge clk)
    begin
        if (busy_start)
        begin
            mode_q <= mode;
            fill_q <= fill;
        end
    end

    // Per-lane credits
    always_ff @ (posedge clk)
    begin
        for (int k = 0; k < n_lanes; k++)
        begin
            if (rst)
                credit_cnt[k] <= w_credit'(lane_depth);
            else
                credit_cnt[k] <= credit_cnt[k]
                               - w_credit'(req_valid[k])
                               + w_credit'(credit_ret[k]);
        end
    end

endmodule

// ==== hw/pattern_lane.sv ====
module pattern_lane
# (
    parameter int screen_width = 640,
    parameter int lane_depth   = 2
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  engine_pkg::lane_req_t req,
    input  logic                  pop,
    output logic                  out_avail,
    output video_pkg::pixel_t     out_pix
);

    import video_pkg::*;
    import engine_pkg::*;

    localparam int w_ptr   = lane_depth > 1 ? $clog2 (lane_depth) : 1;
    localparam int w_count = $clog2 (lane_depth + 1);

    logic                 s1_valid;
    lane_req_t            s1_req;
    logic [2:0]           s1_bar;
    logic                 s1_tile;
    rgb565_t              s2_color;

    pixel_t               queue [lane_depth];
    logic [w_ptr   - 1:0] wr_ptr;
    logic [w_ptr   - 1:0] rd_ptr;
    logic [w_count - 1:0] count;

    function automatic logic [w_ptr - 1:0] ptr_next (logic [w_ptr - 1:0] ptr);
        return (ptr == w_ptr'(lane_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    //------------------------------------------------------------------------
    // Stage one registers the request with its bar index and checker tile

    always_ff @ (posedge clk)
    begin
        if (rst)
            s1_valid <= 1'b0;
        else
            s1_valid <= req_valid;
    end

    always_ff @ (posedge clk)
    begin
        if (req_valid)
        begin
            s1_req  <= req;
            s1_bar  <= 3'((int'(req.x) * 8) / screen_width);
            s1_tile <= req.x[3] ^ req.y[3];
        end
    end

    //------------------------------------------------------------------------
    // Stage two forms the colour and writes it into the queue

    always_comb
    begin
        case (s1_req.mode)
        pat_gradient:
            s2_color = pack_rgb565 (s1_req.x[4:0], s1_req.y[5:0], 5'(s1_req.x + s1_req.y));
        pat_checker:
            s2_color = s1_tile ? rgb_white : rgb_black;
        pat_solid:
            s2_color = s1_req.fill;
        pat_bars:
            s2_color = pack_rgb565 ({w_red   {s1_bar[2]}},
                                    {w_green {s1_bar[1]}},
                                    {w_blue  {s1_bar[0]}});
        default:
            s2_color = rgb_black;
        endcase
    end

    always_ff @ (posedge clk)
    begin
        if (s1_valid)
            queue[wr_ptr] <= '{x: s1_req.x, y: s1_req.y, color: s2_color, eof: s1_req.eof};
    end

    // Credits cover the pipeline too, so the queue cannot overflow
    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (s1_valid)
                wr_ptr <= ptr_next (wr_ptr);
            if (pop)
                rd_ptr <= ptr_next (rd_ptr);
            count <= count + w_count'(s1_valid) - w_count'(pop);
        end
    end

    assign out_avail = (count != '0);
    assign out_pix   = queue[rd_ptr];

endmodule

// ==== hw/pixel_collector.sv ====
module pixel_collector
# (
    parameter int n_lanes      = 4,
    parameter int sink_credits = 4
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [n_lanes - 1:0] out_avail,
    input  video_pkg::pixel_t    out_pix [n_lanes],
    input  logic                 sink_credit,
    input  logic                 busy_start,
    output logic [n_lanes - 1:0] pop,
    output logic [n_lanes - 1:0] credit_ret,
    output logic                 pix_valid,
    output video_pkg::pixel_t    pix,
    output logic                 busy
);

    localparam int w_head = n_lanes > 1 ? $clog2 (n_lanes) : 1;
    localparam int w_sink = $clog2 (sink_credits + 1);

    logic [w_head - 1:0] head;
    logic [w_sink - 1:0] sink_cnt;
    logic                emit;

    //------------------------------------------------------------------------

    // Head lane holds the next pixel in raster order
    assign emit = out_avail[head] && (sink_cnt != '0);

    always_comb
    begin
        pop = '0;
        if (emit)
            pop[head] = 1'b1;
    end

    // Each pop frees one slot in that lane
    assign credit_ret = pop;

    //------------------------------------------------------------------------

    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            head     <= '0;
            sink_cnt <= w_sink'(sink_credits);
        end
        else
        begin
            if (emit)
                head <= (head == w_head'(n_lanes - 1)) ? '0 : head + 1'b1;

            sink_cnt <= sink_cnt - w_sink'(emit) + w_sink'(sink_credit);
        end
    end

    always_ff @ (posedge clk)
    begin
        if (emit)
            pix <= out_pix[head];
    end

    // Busy drops as the eof pixel goes out
    always_ff @ (posedge clk)
    begin
        if (rst)
        begin
            pix_valid <= 1'b0;
            busy      <= 1'b0;
        end
        else
        begin
            pix_valid <= emit;

            if (busy_start)
                busy <= 1'b1;
            else if (emit && out_pix[head].eof)
                busy <= 1'b0;
        end
    end

endmodule

// ==== hw/lcd_pixel_engine.sv ====
module lcd_pixel_engine
# (
    parameter int screen_width  = 640,
    parameter int screen_height = 480,
    parameter int n_lanes       = 4,
    parameter int lane_depth    = 2,
    parameter int sink_credits  = 4
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  engine_pkg::pattern_mode_t mode,
    input  video_pkg::rgb565_t        fill,
    input  logic                      sink_credit,
    output logic                      pix_valid,
    output video_pkg::pixel_t         pix,
    output logic                      busy
);

    import video_pkg::*;
    import engine_pkg::*;

    logic [n_lanes - 1:0] req_valid;
    lane_req_t            req;
    logic                 busy_start;
    logic [n_lanes - 1:0] credit_ret;
    logic [n_lanes - 1:0] out_avail;
    pixel_t               lane_pix [n_lanes];
    logic [n_lanes - 1:0] pop;

    //------------------------------------------------------------------------

    pixel_dispatcher
    # (
        .screen_width  ( screen_width  ),
        .screen_height ( screen_height ),
        .n_lanes       ( n_lanes       ),
        .lane_depth    ( lane_depth    )
    )
    i_pixel_dispatcher
    (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .start         ( start         ),
        .mode          ( mode          ),
        .fill          ( fill          ),
        .credit_ret    ( credit_ret    ),
        .req_valid     ( req_valid     ),
        .req           ( req           ),
        .busy_start    ( busy_start    )
    );

    //------------------------------------------------------------------------

    // All lanes see the same request bus, each with its own valid
    for (genvar k = 0; k < n_lanes; k++)
    begin : gen_lane
        pattern_lane
        # (
            .screen_width ( screen_width  ),
            .lane_depth   ( lane_depth    )
        )
        i_pattern_lane
        (
            .clk          ( clk           ),
            .rst          ( rst           ),
            .req_valid    ( req_valid [k] ),
            .req          ( req           ),
            .pop          ( pop       [k] ),
            .out_avail    ( out_avail [k] ),
            .out_pix      ( lane_pix  [k] )
        );
    end

    //------------------------------------------------------------------------

    pixel_collector
    # (
        .n_lanes      ( n_lanes      ),
        .sink_credits ( sink_credits )
    )
    i_pixel_collector
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .out_avail    ( out_avail    ),
        .out_pix      ( lane_pix     ),
        .sink_credit  ( sink_credit  ),
        .busy_start   ( busy_start   ),
        .pop          ( pop          ),
        .credit_ret   ( credit_ret   ),
        .pix_valid    ( pix_valid    ),
        .pix          ( pix          ),
        .busy         ( busy         )
    );

endmodule

// ==== dv/tb_lcd_pixel_engine.sv ====
module tb_lcd_pixel_engine;

    timeunit 1ns;
    timeprecision 100ps;

    import video_pkg::*;
    import engine_pkg::*;

    localparam int screen_width  = 16;
    localparam int screen_height = 8;
    localparam int n_lanes       = 4;
    localparam int lane_depth    = 2;
    localparam int sink_credits  = 4;
    localparam int frame_pixels  = screen_width * screen_height;
    localparam int frame_timeout = 20000;

    logic          clk = 1'b0;
    logic          rst;
    logic          start;
    pattern_mode_t mode;
    rgb565_t       fill;
    logic          sink_credit = 1'b0;
    logic          pix_valid;
    pixel_t        pix;
    logic          busy;

    // Expected frame and scoreboard state
    pattern_mode_t ref_mode;
    rgb565_t       ref_fill;
    int            exp_idx;
    logic          frame_active;
    logic          frame_done;
    int            errors;
    int            pixels_checked;
    int            tests_run;
    int            tests_failed;
    logic          hung;

    // Sink model
    int            max_delay;
    int            wait_cnt;
    int            owed;
    int            credits_held;
    logic          credit_seen;
    int            err_before;

    lcd_pixel_engine
    # (
        .screen_width  ( screen_width  ),
        .screen_height ( screen_height ),
        .n_lanes       ( n_lanes       ),
        .lane_depth    ( lane_depth    ),
        .sink_credits  ( sink_credits  )
    )
    lcd_pixel_engine_i
    (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .start       ( start       ),
        .mode        ( mode        ),
        .fill        ( fill        ),
        .sink_credit ( sink_credit ),
        .pix_valid   ( pix_valid   ),
        .pix         ( pix         ),
        .busy        ( busy        )
    );

    always #4 clk = ~clk;

    //------------------------------------------------------------------------

    function automatic rgb565_t ref_color
    (
        int            x,
        int            y,
        pattern_mode_t m,
        rgb565_t       f
    );
        int bar;
        int r;
        int g;
        int b;
        r   = 0;
        g   = 0;
        b   = 0;
        bar = (x * 8) / screen_width;
        case (m)
        pat_gradient:
        begin
            r = x % 32;
            g = y % 64;
            b = (x + y) % 32;
        end
        pat_checker:
        begin
            // White where the 8 by 8 tile parities differ
            if (((x / 8) % 2) != ((y / 8) % 2))
            begin
                r = 31;
                g = 63;
                b = 31;
            end
        end
        pat_solid:
            return f;
        pat_bars:
        begin
            r = ((bar / 4) % 2 == 1) ? 31 : 0;
            g = ((bar / 2) % 2 == 1) ? 63 : 0;
            b = (bar % 2 == 1)       ? 31 : 0;
        end
        default:
            r = 0;
        endcase
        return rgb565_t'((r << 11) | (g << 5) | b);
    endfunction

    task automatic compare_pixel ();
        int      ex;
        int      ey;
        rgb565_t ec;
        logic    ee;
        if (!frame_active)
        begin
            $display("pixel arrived outside a frame at x %0d y %0d", pix.x, pix.y);
            errors++;
            return;
        end
        ex = exp_idx % screen_width;
        ey = exp_idx / screen_width;
        ec = ref_color (ex, ey, ref_mode, ref_fill);
        ee = (exp_idx == frame_pixels - 1);
        if (pix.x != coord_t'(ex))
        begin
            $display("error: pix.x got %h expected %h", pix.x, coord_t'(ex));
            errors++;
        end
        if (pix.y != coord_t'(ey))
        begin
            $display("error: pix.y got %h expected %h", pix.y, coord_t'(ey));
            errors++;
        end
        if (pix.color != ec)
        begin
            $display("error: pix.color got %h expected %h", pix.color, ec);
            errors++;
        end
        if (pix.eof != ee)
        begin
            $display("error: pix.eof got %h expected %h", pix.eof, ee);
            errors++;
        end
        pixels_checked++;
        exp_idx++;
        if (ee)
        begin
            // busy drops on the same edge as the eof pixel appears
            if (busy)
            begin
                $display("error: busy got %h expected %h", busy, 1'b0);
                errors++;
            end
            frame_active = 1'b0;
            frame_done   = 1'b1;
        end
    endtask

    //------------------------------------------------------------------------
    // Sink with random credit return and the comparing process

    always @(posedge clk)
    begin
        if (rst)
        begin
            sink_credit  <= 1'b0;
            owed         = 0;
            wait_cnt     = 0;
            credits_held = sink_credits;
            credit_seen  = 1'b0;
        end
        else
        begin
            if (pix_valid)
            begin
                if (credits_held == 0)
                begin
                    $display("pixel was sent while the sink had no credit outstanding");
                    errors++;
                end
                else
                begin
                    credits_held--;
                end
                owed++;
                compare_pixel ();
            end

            // A returned credit is usable by the DUT one edge after it samples it
            if (credit_seen)
                credits_held++;
            credit_seen = sink_credit;

            if (owed > 0 && wait_cnt == 0)
            begin
                sink_credit <= 1'b1;
                owed--;
                wait_cnt = int'($urandom % (max_delay + 1));
            end
            else
            begin
                sink_credit <= 1'b0;
                if (wait_cnt > 0)
                    wait_cnt--;
            end
        end
    end

    //------------------------------------------------------------------------

    task automatic wait_frame_done ();
        int cycles;
        cycles = 0;
        while (!frame_done && !hung)
        begin
            @(negedge clk);
            cycles++;
            if (cycles >= frame_timeout)
            begin
                $display("timeout, frame did not finish within %0d cycles", frame_timeout);
                errors++;
                hung = 1'b1;
            end
        end
    endtask

    // Arms the scoreboard, pulses start, then moves mode and fill away
    task automatic run_frame (input pattern_mode_t m, input rgb565_t f);
        if (hung)
            return;
        ref_mode     = m;
        ref_fill     = f;
        exp_idx      = 0;
        frame_done   = 1'b0;
        frame_active = 1'b1;
        @(posedge clk);
        start <= 1'b1;
        mode  <= m;
        fill  <= f;
        @(posedge clk);
        start <= 1'b0;
        mode  <= (m == pat_checker) ? pat_bars : pat_checker;
        fill  <= ~f;
        wait_frame_done ();
    endtask

    task automatic busy_and_restart ();
        int cycles;
        if (hung)
            return;
        ref_mode     = pat_checker;
        ref_fill     = '0;
        exp_idx      = 0;
        frame_done   = 1'b0;
        frame_active = 1'b1;
        @(posedge clk);
        start <= 1'b1;
        mode  <= pat_checker;
        fill  <= '0;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        while (!busy && !hung)
        begin
            @(negedge clk);
            cycles++;
            if (cycles >= 20)
            begin
                $display("busy did not rise after an accepted start");
                errors++;
                hung = 1'b1;
            end
        end
        if (hung)
            return;

        // Second start while busy must be ignored
        @(posedge clk);
        start <= 1'b1;
        mode  <= pat_bars;
        fill  <= 16'hffff;
        @(posedge clk);
        start <= 1'b0;
        wait_frame_done ();
        if (hung)
            return;

        // Window for stray pixels
        repeat (40) @(negedge clk);
        run_frame (pat_bars, 16'h0000);
    endtask

    task automatic report_test (input string name, input int err_start);
        tests_run++;
        if (errors == err_start)
        begin
            $display("test %0d %s passed", tests_run, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s failed with %0d errors", tests_run, name,
                     errors - err_start);
        end
    endtask

    //------------------------------------------------------------------------

    initial
    begin
        void'($urandom(98352));
        rst            = 1'b1;
        start          = 1'b0;
        mode           = pat_gradient;
        fill           = '0;
        max_delay      = 0;
        ref_mode       = pat_gradient;
        ref_fill       = '0;
        exp_idx        = 0;
        frame_active   = 1'b0;
        frame_done     = 1'b0;
        errors         = 0;
        pixels_checked = 0;
        tests_run      = 0;
        tests_failed   = 0;
        hung           = 1'b0;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        err_before = errors;
        max_delay  = 0;
        run_frame (pat_gradient, 16'h0000);
        report_test ("gradient frame", err_before);

        err_before = errors;
        max_delay  = 3;
        run_frame (pat_checker, 16'h0000);
        run_frame (pat_bars, 16'h0000);
        report_test ("checker and bars frames", err_before);

        err_before = errors;
        max_delay  = 2;
        run_frame (pat_solid, 16'ha5c3);
        report_test ("solid frame", err_before);

        err_before = errors;
        max_delay  = 60;
        run_frame (pat_gradient, 16'h0000);
        report_test ("back-pressure", err_before);

        err_before = errors;
        max_delay  = 1;
        busy_and_restart ();
        report_test ("busy and ignored start", err_before);

        $display("%0d tests, %0d failed, %0d pixels checked, %0d errors",
                 tests_run, tests_failed, pixels_checked, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== sim.f ====
hw/video_pkg.sv
hw/engine_pkg.sv
hw/pixel_dispatcher.sv
hw/pattern_lane.sv
hw/pixel_collector.sv
hw/lcd_pixel_engine.sv
dv/tb_lcd_pixel_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f \
    --top-module tb_lcd_pixel_engine -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_lcd_pixel_engine)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^Everything OK$"; then
    exit 0
fi
exit 1
